//--- design/amigaGluePkg.sv
// Shared glue types; addresses carry only A31..A12, so all bases are 4 KB aligned
package amigaGluePkg;

    ////////////////////////////////////////
    // Address and count types
    ////////////////////////////////////////

    // Upper address field, index 0 is A12 and index 19 is A31
    typedef logic [19:0] upperAddr_t;

    // ROM wait states inserted before acknowledge
    typedef logic [3:0] waitStates_t;

    ////////////////////////////////////////
    // Transfer FSM
    ////////////////////////////////////////

    // Bus cycle states in the acknowledge FSM
    typedef enum logic [1:0] {
        idle    = 2'd0,
        romWait = 2'd1,
        ciaWait = 2'd2,
        ack     = 2'd3
    } xferState_t;

    ////////////////////////////////////////
    // Region bases, upper field only
    ////////////////////////////////////////

    // Kickstart ROM at 0x00F8_0000
    localparam upperAddr_t romBase = 20'h00F80;
    // Boot overlay alias at 0x0000_0000
    localparam upperAddr_t romOverlayBase = 20'h00000;
    // CIA page at 0x00BF_0000
    localparam upperAddr_t ciaBase = 20'h00BF0;

endpackage

//--- design/busConfigRegs.sv
// Write-only config; cfgSel 0 takes all four cfgData bits, cfgSel 1 takes bit 0 only
`timescale 1ns/1ps

module busConfigRegs (
    input  logic                      CLK40,
    input  logic                      TS_RESET,
    input  logic                      cfgWrite,
    input  logic                      cfgSel,
    input  logic [3:0]                cfgData,
    output amigaGluePkg::waitStates_t romWaitStates,
    output logic                      ciaEnable
);

    import amigaGluePkg::*;

    // Default ROM timing out of reset
    localparam waitStates_t resetWaitStates = 4'd2;

    // Register select codes
    localparam logic selWaitStates = 1'b0;
    localparam logic selCiaEnable  = 1'b1;

    ////////////////////////////////////////
    // Config fields
    ////////////////////////////////////////

    // ROM wait-state field
    // New value is live from the write edge onward
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            romWaitStates <= resetWaitStates;
        end else if (cfgWrite && (cfgSel == selWaitStates)) begin
            romWaitStates <= cfgData;
        end
    end

    // CIA decode enable
    // Comes up enabled so the boot code can reach the CIAs
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            ciaEnable <= 1'b1;
        end else if (cfgWrite && (cfgSel == selCiaEnable)) begin
            // Upper data bits ignored here
            ciaEnable <= cfgData[0];
        end
    end

endmodule

//--- design/addressDecode.sv
// Pure combinational decode of A31..A12; addr must be stable while selects are used
`timescale 1ns/1ps

module addressDecode (
    input  amigaGluePkg::upperAddr_t addr,
    input  logic                     overlay,
    input  logic                     ciaEnable,
    output logic                     romSpace,
    output logic                     ciaSpace,
    output logic                     ciaSelectA,
    output logic                     ciaSelectB
);

    import amigaGluePkg::*;

    // 512 KB ROM window, compare A31..A19
    localparam int romFieldLsb = 7;
    // 64 KB CIA window, compare A31..A16
    localparam int ciaFieldLsb = 4;

    // Chip select bits inside the CIA page
    localparam int ciaSelBitA = 0;
    localparam int ciaSelBitB = 1;

    logic romNormalHit;
    logic romOverlayHit;

    ////////////////////////////////////////
    // ROM space
    ////////////////////////////////////////

    always_comb begin
        // Normal ROM location
        romNormalHit = (addr[19:romFieldLsb] == romBase[19:romFieldLsb]);

        // Overlay alias at zero for the reset vector fetch
        romOverlayHit = overlay &&
            (addr[19:romFieldLsb] == romOverlayBase[19:romFieldLsb]);

        romSpace = romNormalHit || romOverlayHit;
    end

    ////////////////////////////////////////
    // CIA space
    ////////////////////////////////////////

    always_comb begin
        // Whole 0x00BF page, gated by the config bit
        ciaSpace = ciaEnable &&
            (addr[19:ciaFieldLsb] == ciaBase[19:ciaFieldLsb]);

        // CIA-A answers with A12 low
        ciaSelectA = ciaSpace && !addr[ciaSelBitA];

        // CIA-B answers with A13 low
        // Both selected when A12 and A13 are low
        ciaSelectB = ciaSpace && !addr[ciaSelBitB];
    end

endmodule

//--- design/transferAck.sv
// One cycle in flight; starts outside ROM and CIA space are dropped with no acknowledge
`timescale 1ns/1ps

module transferAck (
    input  logic                      CLK40,
    input  logic                      TS_RESET,
    input  logic                      transferStart,
    input  logic                      romSpace,
    input  logic                      ciaSpace,
    input  amigaGluePkg::waitStates_t romWaitStates,
    input  logic                      ciaClockFall,
    output logic                      transferAck,
    output logic                      cacheInhibit,
    output logic                      burstInhibit
);

    import amigaGluePkg::*;

    xferState_t  state;
    waitStates_t waitCount;
    // Set when the latched cycle targets a CIA
    logic        ciaCycle;

    ////////////////////////////////////////
    // Start latch and transfer FSM
    ////////////////////////////////////////

    // The start strobe is a single clock wide
    // Capturing it straight into the state keeps it from being lost
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            state     <= idle;
            waitCount <= '0;
            ciaCycle  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // ROM has priority if both decode, which the map never allows
                    if (transferStart && romSpace) begin
                        state     <= romWait;
                        waitCount <= romWaitStates;
                        ciaCycle  <= 1'b0;
                    end else if (transferStart && ciaSpace) begin
                        state    <= ciaWait;
                        ciaCycle <= 1'b1;
                    end
                end

                romWait: begin
                    // Count out the programmed waits
                    // Zero waits still costs one edge here
                    if (waitCount == '0) begin
                        state <= ack;
                    end else begin
                        waitCount <= waitCount - 4'd1;
                    end
                end

                ciaWait: begin
                    // Sync to the E-clock style falling edge
                    // A fall strobe already sampled on the start edge is not seen here
                    if (ciaClockFall) begin
                        state <= ack;
                    end
                end

                ack: begin
                    // Back to idle, which frees the latch
                    state    <= idle;
                    ciaCycle <= 1'b0;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Acknowledge and inhibit levels
    ////////////////////////////////////////

    // Decoded from registered state, so glitch free
    always_comb begin
        transferAck  = (state == ack);

        // Neither ROM nor CIA may burst
        burstInhibit = (state == ack);

        // CIA registers must never be cached
        cacheInhibit = (state == ack) && ciaCycle;
    end

endmodule

//--- design/ciaClockGen.sv
// ciaHalfPeriod must be at least 1; clock period is twice the half period in CLK40 cycles
`timescale 1ns/1ps

module ciaClockGen #(
    parameter logic [7:0] ciaHalfPeriod = 8'd28
) (
    input  logic CLK40,
    input  logic TS_RESET,
    output logic ciaClock,
    output logic ciaClockFall
);

    // Last count value of each phase
    localparam logic [7:0] lastCount = ciaHalfPeriod - 8'd1;

    logic [7:0] phaseCount;
    logic       phaseEnd;

    ////////////////////////////////////////
    // Phase counter
    ////////////////////////////////////////

    assign phaseEnd = (phaseCount == lastCount);

    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            phaseCount <= '0;
        end else if (phaseEnd) begin
            phaseCount <= '0;
        end else begin
            phaseCount <= phaseCount + 8'd1;
        end
    end

    ////////////////////////////////////////
    // CIA clock and fall strobe
    ////////////////////////////////////////

    // Starts low, first rise after one half period
    // Fall strobe is registered with the clock, so both change together
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            ciaClock     <= 1'b0;
            ciaClockFall <= 1'b0;
        end else begin
            if (phaseEnd) begin
                ciaClock <= !ciaClock;
            end
            // High only in the cycle where the clock drops
            ciaClockFall <= phaseEnd && ciaClock;
        end
    end

endmodule

//--- design/tickGen.sv
// Dividers are counted in CLK40 cycles and must be at least 2; ticks are not phase related
`timescale 1ns/1ps

module tickGen #(
    parameter logic [31:0] tick60Divider = 32'd666667,
    parameter logic [31:0] tick50Divider = 32'd800000
) (
    input  logic CLK40,
    input  logic TS_RESET,
    output logic tick60,
    output logic tick50
);

    // Index 0 is the 60 Hz tick, index 1 the 50 Hz tick
    logic [1:0] tickPulse;

    ////////////////////////////////////////
    // Wrap-around dividers
    ////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin : g_tick
        localparam logic [31:0] divider   = (i == 0) ? tick60Divider : tick50Divider;
        localparam logic [31:0] lastCount = divider - 32'd1;

        logic [31:0] count;

        // Pulse on the wrap edge
        // First pulse one full divider after reset
        always_ff @(posedge CLK40 or posedge TS_RESET) begin
            if (TS_RESET) begin
                count        <= '0;
                tickPulse[i] <= 1'b0;
            end else if (count == lastCount) begin
                count        <= '0;
                tickPulse[i] <= 1'b1;
            end else begin
                count        <= count + 32'd1;
                tickPulse[i] <= 1'b0;
            end
        end
    end

    // Vertical blank style ticks for the CIA TOD inputs
    assign tick60 = tickPulse[0];
    assign tick50 = tickPulse[1];

endmodule

//--- design/amigaGlueTop.sv
// CLK40 only; no data buffer control, acknowledge is a plain active-high pulse
`timescale 1ns/1ps

module amigaGlueTop #(
    parameter logic [31:0] tick60Divider = 32'd666667,
    parameter logic [31:0] tick50Divider = 32'd800000,
    parameter logic [7:0]  ciaHalfPeriod = 8'd28
) (
    input  logic                     CLK40,
    input  logic                     TS_RESET,
    input  logic                     transferStart,
    input  amigaGluePkg::upperAddr_t addr,
    input  logic                     overlay,
    input  logic                     cfgWrite,
    input  logic                     cfgSel,
    input  logic [3:0]               cfgData,
    output logic                     romEnable,
    output logic                     ciaSelectA,
    output logic                     ciaSelectB,
    output logic                     transferAck,
    output logic                     cacheInhibit,
    output logic                     burstInhibit,
    output logic                     ciaClock,
    output logic                     tick60,
    output logic                     tick50
);

    import amigaGluePkg::*;

    waitStates_t romWaitStates;
    logic        ciaEnable;
    logic        ciaSpace;
    logic        ciaClockFall;

    ////////////////////////////////////////
    // Config and decode
    ////////////////////////////////////////

    busConfigRegs u_busConfigRegs (
        .CLK40         (CLK40),
        .TS_RESET      (TS_RESET),
        .cfgWrite      (cfgWrite),
        .cfgSel        (cfgSel),
        .cfgData       (cfgData),
        .romWaitStates (romWaitStates),
        .ciaEnable     (ciaEnable)
    );

    // ROM space doubles as the ROM chip enable
    addressDecode u_addressDecode (
        .addr       (addr),
        .overlay    (overlay),
        .ciaEnable  (ciaEnable),
        .romSpace   (romEnable),
        .ciaSpace   (ciaSpace),
        .ciaSelectA (ciaSelectA),
        .ciaSelectB (ciaSelectB)
    );

    ////////////////////////////////////////
    // Acknowledge and clocks
    ////////////////////////////////////////

    transferAck u_transferAck (
        .CLK40         (CLK40),
        .TS_RESET      (TS_RESET),
        .transferStart (transferStart),
        .romSpace      (romEnable),
        .ciaSpace      (ciaSpace),
        .romWaitStates (romWaitStates),
        .ciaClockFall  (ciaClockFall),
        .transferAck   (transferAck),
        .cacheInhibit  (cacheInhibit),
        .burstInhibit  (burstInhibit)
    );

    ciaClockGen #(
        .ciaHalfPeriod (ciaHalfPeriod)
    ) u_ciaClockGen (
        .CLK40        (CLK40),
        .TS_RESET     (TS_RESET),
        .ciaClock     (ciaClock),
        .ciaClockFall (ciaClockFall)
    );

    tickGen #(
        .tick60Divider (tick60Divider),
        .tick50Divider (tick50Divider)
    ) u_tickGen (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .tick60   (tick60),
        .tick50   (tick50)
    );

endmodule

//--- verif/amigaGlueTb.sv
// Runs the glue with short dividers (ticks 50 and 60, CIA half period 6); limits assume these
`timescale 1ns/1ps

module amigaGlueTb;

    import amigaGluePkg::*;

    // Short dividers keep the run brief
    localparam logic [31:0] tick60Cycles  = 32'd50;
    localparam logic [31:0] tick50Cycles  = 32'd60;
    localparam logic [7:0]  ciaHalfCycles = 8'd6;

    // Acknowledge kinds returned by the reference
    localparam logic [1:0] kindNone = 2'd0;
    localparam logic [1:0] kindRom  = 2'd1;
    localparam logic [1:0] kindCia  = 2'd2;

    localparam int ackTimeout  = 40;
    localparam int tickTimeout = 200;

    logic       CLK40 = 1'b0;
    logic       TS_RESET;
    logic       transferStart;
    upperAddr_t addr;
    logic       overlay;
    logic       cfgWrite;
    logic       cfgSel;
    logic [3:0] cfgData;
    logic       romEnable;
    logic       ciaSelectA;
    logic       ciaSelectB;
    logic       transferAck;
    logic       cacheInhibit;
    logic       burstInhibit;
    logic       ciaClock;
    logic       tick60;
    logic       tick50;

    // Expected config contents, updated on the write edge
    waitStates_t waitModel;
    logic        ciaEnableModel;

    logic        decodeCheckOn;
    logic [9:0]  decodeExpected;
    string       currentTest;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          failedTests;
    int          testStartErrors;
    integer      seed;

    logic [3:0]  romWaitList [3] = '{4'd0, 4'd2, 4'd7};

    amigaGlueTop #(
        .tick60Divider (tick60Cycles),
        .tick50Divider (tick50Cycles),
        .ciaHalfPeriod (ciaHalfCycles)
    ) u_amigaGlueTop (
        .CLK40         (CLK40),
        .TS_RESET      (TS_RESET),
        .transferStart (transferStart),
        .addr          (addr),
        .overlay       (overlay),
        .cfgWrite      (cfgWrite),
        .cfgSel        (cfgSel),
        .cfgData       (cfgData),
        .romEnable     (romEnable),
        .ciaSelectA    (ciaSelectA),
        .ciaSelectB    (ciaSelectB),
        .transferAck   (transferAck),
        .cacheInhibit  (cacheInhibit),
        .burstInhibit  (burstInhibit),
        .ciaClock      (ciaClock),
        .tick60        (tick60),
        .tick50        (tick50)
    );

    // 8 ns period
    always #4 CLK40 = ~CLK40;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Packed as {latency[4:0], kind[1:0], romEnable, ciaSelectA, ciaSelectB}
    function automatic logic [9:0] expectedBus(input upperAddr_t a, input logic ovl,
                                               input logic ciaEn, input waitStates_t ws);
        logic       romHit;
        logic       ciaHit;
        logic [1:0] kind;
        logic [4:0] latency;
        // ROM is 512 KB from its base, overlay alias 512 KB from zero
        romHit = ((a >= romBase) && (a <= romBase + 20'h0007F)) ||
                 (ovl && (a <= romOverlayBase + 20'h0007F));
        // CIA page is 64 KB
        ciaHit = ciaEn && (a >= ciaBase) && (a <= ciaBase + 20'h0000F);
        kind = romHit ? kindRom : (ciaHit ? kindCia : kindNone);
        // ROM ack lands wait states plus one edges after the start edge
        latency = romHit ? ({1'b0, ws} + 5'd1) : 5'd0;
        // A12 low picks CIA-A, A13 low picks CIA-B
        return {latency, kind, romHit, ciaHit && !a[0], ciaHit && !a[1]};
    endfunction

    ////////////////////////////////////////
    // Checks and bookkeeping
    ////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     currentTest, what, expected, actual);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("%s: timed out waiting for %s", currentTest, what);
    endtask

    task automatic startTest(input string name);
        currentTest     = name;
        testStartErrors = errorCount;
    endtask

    task automatic finishTest();
        int n;
        n = errorCount - testStartErrors;
        testCount++;
        if (n == 0) begin
            $display("%s: ok", currentTest);
        end else begin
            failedTests++;
            $display("%s: %0d errors", currentTest, n);
        end
    endtask

    // Decode is checked every cycle against the reference once enabled
    always @(negedge CLK40) begin
        if (decodeCheckOn) begin
            decodeExpected = expectedBus(addr, overlay, ciaEnableModel, waitModel);
            checkValue("romEnable", 32'(decodeExpected[2]), 32'(romEnable));
            checkValue("ciaSelectA", 32'(decodeExpected[1]), 32'(ciaSelectA));
            checkValue("ciaSelectB", 32'(decodeExpected[0]), 32'(ciaSelectB));
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Region 0 ROM, 1..4 CIA with A13/A12 = region-1, 5 overlay, 6 unmapped
    task automatic randomAddress(input int region, output upperAddr_t a);
        logic [31:0] r;
        logic [1:0]  selBits;
        r = $random(seed);
        selBits = 2'(region - 1);
        if (region == 0) begin
            a = romBase + {13'd0, r[6:0]};
        end else if (region <= 4) begin
            a = {ciaBase[19:4], r[3:2], selBits};
        end else if (region == 5) begin
            a = romOverlayBase + {13'd0, r[6:0]};
        end else if (r[31:30] == 2'b00) begin
            // Just above the overlay alias
            a = 20'h00080 + {12'd0, r[7:0]};
        end else if (r[31:30] == 2'b01) begin
            a = 20'h00C00 + {11'd0, r[8:0]};
        end else begin
            a = {1'b1, r[18:0]};
        end
    endtask

    task automatic writeConfig(input logic sel, input logic [3:0] data);
        @(posedge CLK40);
        cfgWrite <= 1'b1;
        cfgSel   <= sel;
        cfgData  <= data;
        @(posedge CLK40);
        cfgWrite <= 1'b0;
        // Takes effect on this edge
        if (sel) begin
            ciaEnableModel = data[0];
        end else begin
            waitModel = data;
        end
    endtask

    // One bus cycle, checked against the reference acknowledge kind
    task automatic runTransfer(input upperAddr_t a);
        logic [9:0] expected;
        int         cycles;
        int         fallCycle;
        bit         seen;
        bit         fallSeen;
        logic       prevClock;
        expected = expectedBus(a, overlay, ciaEnableModel, waitModel);
        @(posedge CLK40);
        transferStart <= 1'b1;
        addr          <= a;
        @(negedge CLK40);
        prevClock = ciaClock;
        // Start edge
        @(posedge CLK40);
        transferStart <= 1'b0;
        cycles    = 0;
        fallCycle = 0;
        seen      = 1'b0;
        fallSeen  = 1'b0;
        // Index counts edges since the start edge
        while (!seen && cycles < ackTimeout) begin
            @(negedge CLK40);
            if (prevClock && !ciaClock && !fallSeen) begin
                fallSeen  = 1'b1;
                fallCycle = cycles;
            end
            prevClock = ciaClock;
            if (transferAck) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (expected[4:3] == kindNone) begin
            checkValue("unmapped transferAck", 32'd0, 32'(seen));
        end else if (!seen) begin
            reportTimeout("transferAck");
        end else begin
            if (expected[4:3] == kindRom) begin
                checkValue("ack latency", 32'(expected[9:5]), cycles);
            end else if (!fallSeen) begin
                $display("%s: acknowledge came with no CIA clock fall before it", currentTest);
                errorCount++;
            end else begin
                checkValue("ack after fall", fallCycle + 1, cycles);
            end
            checkValue("burstInhibit", 32'd1, 32'(burstInhibit));
            checkValue("cacheInhibit", 32'(expected[4:3] == kindCia), 32'(cacheInhibit));
            // Single-cycle pulse
            @(negedge CLK40);
            checkValue("ack width", 32'd0, 32'(transferAck));
        end
    endtask

    // Edges until the chosen tick is seen high
    task automatic waitTick(input bit use50, output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < tickTimeout) begin
            @(posedge CLK40);
            cycles++;
            @(negedge CLK40);
            seen = use50 ? tick50 : tick60;
        end
    endtask

    task automatic measureTicks(input bit use50, input int expected);
        int cycles;
        int period;
        bit seen;
        // Align to a pulse first
        waitTick(use50, cycles, seen);
        for (period = 0; period < 3 && seen; period++) begin
            waitTick(use50, cycles, seen);
            if (seen) begin
                checkValue(use50 ? "tick50 interval" : "tick60 interval", expected, cycles);
            end
        end
        if (!seen) begin
            reportTimeout(use50 ? "tick50" : "tick60");
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int         ovlPass;
        int         n;
        int         cycles;
        bit         risen;
        upperAddr_t a;
        seed           = 1193;
        errorCount     = 0;
        checkCount     = 0;
        testCount      = 0;
        failedTests    = 0;
        decodeCheckOn  = 1'b0;
        waitModel      = 4'd2;
        ciaEnableModel = 1'b1;
        TS_RESET       = 1'b1;
        transferStart  = 1'b0;
        addr           = '0;
        overlay        = 1'b0;
        cfgWrite       = 1'b0;
        cfgSel         = 1'b0;
        cfgData        = 4'd0;

        // Reset values and first CIA clock rise
        startTest("reset");
        repeat (8) @(posedge CLK40);
        TS_RESET <= 1'b0;
        @(negedge CLK40);
        checkValue("transferAck", 32'd0, 32'(transferAck));
        checkValue("cacheInhibit", 32'd0, 32'(cacheInhibit));
        checkValue("burstInhibit", 32'd0, 32'(burstInhibit));
        checkValue("tick60", 32'd0, 32'(tick60));
        checkValue("tick50", 32'd0, 32'(tick50));
        checkValue("ciaClock", 32'd0, 32'(ciaClock));
        cycles = 0;
        risen  = 1'b0;
        while (!risen && cycles < ackTimeout) begin
            @(posedge CLK40);
            cycles++;
            @(negedge CLK40);
            risen = ciaClock;
        end
        if (risen) begin
            checkValue("ciaClock first rise", 32'(ciaHalfCycles), cycles);
        end else begin
            reportTimeout("the first ciaClock rise");
        end
        finishTest();

        // Decode sweep, overlay off then on
        @(posedge CLK40);
        decodeCheckOn = 1'b1;
        startTest("decode");
        for (ovlPass = 0; ovlPass < 2; ovlPass++) begin
            @(posedge CLK40);
            overlay <= ovlPass[0];
            for (n = 0; n < 56; n++) begin
                randomAddress(n % 7, a);
                @(posedge CLK40);
                addr <= a;
            end
        end
        @(posedge CLK40);
        finishTest();

        // ROM acknowledge for each wait-state setting
        startTest("romAck");
        overlay <= 1'b0;
        for (n = 0; n < 3; n++) begin
            writeConfig(1'b0, romWaitList[n]);
            randomAddress(0, a);
            runTransfer(a);
        end
        randomAddress(6, a);
        runTransfer(a);
        finishTest();

        // CIA acknowledge across all select combinations
        startTest("ciaAck");
        for (n = 0; n < 8; n++) begin
            randomAddress(1 + (n % 4), a);
            runTransfer(a);
        end
        // CIA decode switched off
        writeConfig(1'b1, 4'd0);
        randomAddress(1, a);
        runTransfer(a);
        writeConfig(1'b1, 4'd1);
        finishTest();

        startTest("ticks");
        measureTicks(1'b0, tick60Cycles);
        measureTicks(1'b1, tick50Cycles);
        finishTest();

        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- amigaGlueTop.f
design/amigaGluePkg.sv
design/busConfigRegs.sv
design/addressDecode.sv
design/transferAck.sv
design/ciaClockGen.sv
design/tickGen.sv
design/amigaGlueTop.sv
verif/amigaGlueTb.sv

//--- Makefile
# Verilator flow for the glue logic testbench

VERILATOR := verilator
FLAGS     := --timing
TOP       := amigaGlueTb
FILELIST  := amigaGlueTop.f
BUILD_DIR := obj_dir
PASS_TEXT := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
